// ==== hw/ooo_pkg.sv ====
`default_nettype none

package ooo_pkg;

    typedef logic [4:0] arch_reg_t;
    typedef logic [5:0] phys_reg_t;   // 64 physical registers
    typedef logic [3:0] rob_idx_t;

    typedef struct packed {
        logic [6:0] funct7;
        arch_reg_t  rs2;
        arch_reg_t  rs1;
        logic [2:0] funct3;
        arch_reg_t  rd;
        logic [6:0] opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0] imm;
        arch_reg_t   rs1;
        logic [2:0]  funct3;
        arch_reg_t   rd;
        logic [6:0]  opcode;
    } i_view_t;

    // same word, register or immediate layout
    typedef union packed {
        r_view_t r;
        i_view_t i;
    } inst_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef struct packed {
        alu_op_e     alu_op;
        logic        use_imm;
        logic [31:0] imm;      // sign extended
        phys_reg_t   ps1;
        phys_reg_t   ps2;
        logic        ps1_ready;
        logic        ps2_ready;
        phys_reg_t   pd;
        arch_reg_t   rd;
        logic        writes_rd;
        rob_idx_t    rob_idx;
    } uop_t;

    typedef struct packed {
        logic        valid;
        phys_reg_t   pd;
        rob_idx_t    rob_idx;
        logic [31:0] value;
        logic        writes_rd;
    } cdb_t;

    typedef struct packed {
        arch_reg_t   rd;
        logic        writes_rd;
        logic [31:0] value;
        logic [31:0] order;
    } commit_t;

endpackage

`default_nettype wire

// ==== hw/inst_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_queue #(
    parameter int IQ_DEPTH = 8
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           push_i,
    input  ooo_pkg::inst_u push_data_i,
    input  logic           pop_i,
    output ooo_pkg::inst_u head_o,
    output logic           empty_o,
    output logic           credit_o
);

    localparam int AW = $clog2(IQ_DEPTH);

    ooo_pkg::inst_u mem [IQ_DEPTH];
    logic [AW:0]    wr_ptr;
    logic [AW:0]    rd_ptr;   // extra bit tells full from empty
    logic           full;

    assign empty_o = wr_ptr == rd_ptr;
    assign full    = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign head_o  = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr[AW-1:0]] <= push_data_i;
        end
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            credit_o <= 1'b0;
        end else begin
            if (push_i) wr_ptr <= wr_ptr + 1'b1;
            if (pop_i) rd_ptr <= rd_ptr + 1'b1;
            credit_o <= pop_i;   // one credit back per dequeue
        end
    end

    // sender broke the credit rule
    assert property (@(posedge clk) disable iff (rst) push_i |-> !full);

endmodule

`default_nettype wire

// ==== hw/free_list.sv ====
`timescale 1ns/1ps
`default_nettype none

module free_list (
    input  logic               clk,
    input  logic               rst,
    input  logic               alloc_i,
    output ooo_pkg::phys_reg_t tag_o,
    output logic               empty_o,
    input  logic               free_i,
    input  ooo_pkg::phys_reg_t free_tag_i
);

    // at most 32 tags are ever free
    ooo_pkg::phys_reg_t mem [32];
    logic [5:0]         head;
    logic [5:0]         tail;

    assign empty_o = head == tail;
    assign tag_o   = mem[head[4:0]];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                mem[i] <= ooo_pkg::phys_reg_t'(32 + i);   // p32..p63
            end
            head <= '0;
            tail <= 6'b100000;   // starts full
        end else begin
            if (alloc_i) head <= head + 1'b1;
            if (free_i) begin
                mem[tail[4:0]] <= free_tag_i;
                tail           <= tail + 1'b1;
            end
        end
    end

    // dispatch must wait for a tag
    assert property (@(posedge clk) disable iff (rst) alloc_i |-> !empty_o);

endmodule

`default_nettype wire

// ==== hw/rename_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_dispatch (
    input  logic               clk,
    input  logic               rst,
    input  ooo_pkg::inst_u     inst_i,
    input  logic               iq_empty_i,
    output logic               pop_o,
    input  logic               fl_empty_i,
    input  ooo_pkg::phys_reg_t fl_tag_i,
    output logic               fl_alloc_o,
    input  logic               rob_full_i,
    input  ooo_pkg::rob_idx_t  rob_tail_i,
    output logic               rob_push_o,
    output ooo_pkg::phys_reg_t old_pd_o,
    input  logic               rs_full_i,
    output ooo_pkg::uop_t      uop_o,
    input  ooo_pkg::cdb_t      cdb_i
);

    localparam logic [6:0] OP_REG = 7'b0110011;
    localparam logic [6:0] OP_IMM = 7'b0010011;

    ooo_pkg::phys_reg_t rat [32];
    logic [63:0]        ready_tbl;
    ooo_pkg::phys_reg_t ps1;
    ooo_pkg::phys_reg_t ps2;
    ooo_pkg::alu_op_e   alu_op;
    logic               is_reg;
    logic               is_imm;
    logic               writes_rd;
    logic               cdb_wr;
    logic               fire;

    assign is_reg    = inst_i.r.opcode == OP_REG;
    assign is_imm    = inst_i.i.opcode == OP_IMM;
    assign writes_rd = (is_reg || is_imm) && (inst_i.r.rd != '0);   // x0 and unknown ops
    assign cdb_wr    = cdb_i.valid && cdb_i.writes_rd;
    assign ps1       = rat[inst_i.r.rs1];
    assign ps2       = rat[inst_i.r.rs2];

    assign fire       = !iq_empty_i && !rob_full_i && !rs_full_i && (!fl_empty_i || !writes_rd);
    assign pop_o      = fire;
    assign rob_push_o = fire;
    assign fl_alloc_o = fire && writes_rd;
    assign old_pd_o   = rat[inst_i.r.rd];

    // funct7 bit 5 also marks srai in the immediate view
    always_comb begin
        case (inst_i.r.funct3)
            3'd0: alu_op = (is_reg && inst_i.r.funct7[5]) ? ooo_pkg::ALU_SUB : ooo_pkg::ALU_ADD;
            3'd1: alu_op = ooo_pkg::ALU_SLL;
            3'd2: alu_op = ooo_pkg::ALU_SLT;
            3'd3: alu_op = ooo_pkg::ALU_SLTU;
            3'd4: alu_op = ooo_pkg::ALU_XOR;
            3'd5: alu_op = inst_i.r.funct7[5] ? ooo_pkg::ALU_SRA : ooo_pkg::ALU_SRL;
            3'd6: alu_op = ooo_pkg::ALU_OR;
            3'd7: alu_op = ooo_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        uop_o.alu_op    = alu_op;
        uop_o.use_imm   = is_imm;
        uop_o.imm       = {{20{inst_i.i.imm[11]}}, inst_i.i.imm};
        uop_o.ps1       = ps1;
        uop_o.ps2       = ps2;
        // a tag on the cdb this cycle counts as ready
        uop_o.ps1_ready = !(is_reg || is_imm) || ready_tbl[ps1] || (cdb_wr && cdb_i.pd == ps1);
        uop_o.ps2_ready = !is_reg || ready_tbl[ps2] || (cdb_wr && cdb_i.pd == ps2);
        uop_o.pd        = fl_tag_i;
        uop_o.rd        = inst_i.r.rd;
        uop_o.writes_rd = writes_rd;
        uop_o.rob_idx   = rob_tail_i;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                rat[i] <= ooo_pkg::phys_reg_t'(i);
            end
            ready_tbl <= '1;
        end else begin
            if (cdb_wr) ready_tbl[cdb_i.pd] <= 1'b1;
            if (fl_alloc_o) begin
                rat[inst_i.r.rd]    <= fl_tag_i;
                ready_tbl[fl_tag_i] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/reorder_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer #(
    parameter int ROB_DEPTH = 16
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               push_i,
    input  ooo_pkg::uop_t      push_uop_i,
    input  ooo_pkg::phys_reg_t old_pd_i,
    output ooo_pkg::rob_idx_t  tail_o,
    output logic               full_o,
    input  ooo_pkg::cdb_t      cdb_i,
    output logic               commit_valid_o,
    output ooo_pkg::commit_t   commit_o,
    output logic               free_o,
    output ooo_pkg::phys_reg_t free_tag_o
);

    localparam int AW = $clog2(ROB_DEPTH);

    typedef struct packed {
        ooo_pkg::arch_reg_t rd;
        logic               writes_rd;
        ooo_pkg::phys_reg_t old_pd;
        logic [31:0]        value;
    } rob_entry_t;

    rob_entry_t           ent [ROB_DEPTH];
    rob_entry_t           head_ent;
    logic [ROB_DEPTH-1:0] done;
    logic [AW:0]          head;
    logic [AW:0]          tail;
    logic [31:0]          order_cnt;
    logic                 empty;
    logic                 retire;

    assign empty    = head == tail;
    assign full_o   = (head[AW] != tail[AW]) && (head[AW-1:0] == tail[AW-1:0]);
    assign tail_o   = ooo_pkg::rob_idx_t'(tail[AW-1:0]);
    assign head_ent = ent[head[AW-1:0]];
    assign retire   = !empty && done[head[AW-1:0]];

    always_ff @(posedge clk) begin
        if (push_i) begin
            ent[tail[AW-1:0]].rd        <= push_uop_i.rd;
            ent[tail[AW-1:0]].writes_rd <= push_uop_i.writes_rd;
            ent[tail[AW-1:0]].old_pd    <= old_pd_i;
        end
        if (cdb_i.valid) ent[cdb_i.rob_idx[AW-1:0]].value <= cdb_i.value;
        commit_o <= '{rd: head_ent.rd, writes_rd: head_ent.writes_rd,
                      value: head_ent.value, order: order_cnt};
        free_tag_o <= head_ent.old_pd;   // previous mapping of rd
        if (rst) begin
            head           <= '0;
            tail           <= '0;
            done           <= '0;
            order_cnt      <= '0;
            commit_valid_o <= 1'b0;
            free_o         <= 1'b0;
        end else begin
            if (push_i) begin
                tail                 <= tail + 1'b1;
                done[tail[AW-1:0]]   <= 1'b0;
            end
            if (cdb_i.valid) done[cdb_i.rob_idx[AW-1:0]] <= 1'b1;
            if (retire) begin
                head      <= head + 1'b1;
                order_cnt <= order_cnt + 1'b1;
            end
            commit_valid_o <= retire;
            free_o         <= retire && head_ent.writes_rd;
        end
    end

    assert property (@(posedge clk) disable iff (rst) push_i |-> !full_o);

    // each entry completes once, and only while it is in flight
    assert property (@(posedge clk) disable iff (rst)
        cdb_i.valid |-> !empty && !done[cdb_i.rob_idx[AW-1:0]]);

endmodule

`default_nettype wire

// ==== hw/reservation_station.sv ====
`timescale 1ns/1ps
`default_nettype none

module reservation_station #(
    parameter int RS_DEPTH = 8
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          push_i,
    input  ooo_pkg::uop_t uop_i,
    output logic          full_o,
    input  ooo_pkg::cdb_t cdb_i,
    output logic          issue_valid_o,
    output ooo_pkg::uop_t issue_uop_o
);

    localparam int AW = $clog2(RS_DEPTH);

    ooo_pkg::uop_t       slot [RS_DEPTH];
    logic [AW-1:0]       age [RS_DEPTH];   // count of older entries
    logic [RS_DEPTH-1:0] valid;
    logic [AW-1:0]       sel;
    logic [AW-1:0]       best_age;
    logic [AW-1:0]       free_idx;
    logic [AW:0]         count;
    logic                found;
    logic                cdb_wr;

    assign cdb_wr        = cdb_i.valid && cdb_i.writes_rd;
    assign full_o        = &valid;
    assign issue_valid_o = found;
    assign issue_uop_o   = slot[sel];

    always_comb begin
        found    = 1'b0;
        sel      = '0;
        best_age = '1;
        free_idx = '0;
        count    = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!valid[i]) free_idx = AW'(i);
        end
        for (int i = 0; i < RS_DEPTH; i++) begin
            count = count + (AW + 1)'(valid[i]);
            if (valid[i] && slot[i].ps1_ready && slot[i].ps2_ready
                && (!found || age[i] < best_age)) begin
                found    = 1'b1;
                sel      = AW'(i);
                best_age = age[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                // wakeup
                if (valid[i] && cdb_wr && slot[i].ps1 == cdb_i.pd) slot[i].ps1_ready <= 1'b1;
                if (valid[i] && cdb_wr && slot[i].ps2 == cdb_i.pd) slot[i].ps2_ready <= 1'b1;
                if (found && valid[i] && age[i] > best_age) age[i] <= age[i] - 1'b1;
            end
            if (found) valid[sel] <= 1'b0;
            if (push_i) begin
                valid[free_idx] <= 1'b1;
                slot[free_idx]  <= uop_i;
                age[free_idx]   <= AW'(count - (AW + 1)'(found));   // youngest
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/phys_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module phys_regfile (
    input  logic               clk,
    input  logic               rst,
    input  ooo_pkg::cdb_t      cdb_i,
    input  ooo_pkg::phys_reg_t rs1_tag_i,
    input  ooo_pkg::phys_reg_t rs2_tag_i,
    output logic [31:0]        rs1_val_o,
    output logic [31:0]        rs2_val_o
);

    logic [31:0] regs [64];
    logic        wr_en;

    assign wr_en = cdb_i.valid && cdb_i.writes_rd;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 64; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[cdb_i.pd] <= cdb_i.value;
        end
    end

    // bypass same-cycle writes
    assign rs1_val_o = (wr_en && cdb_i.pd == rs1_tag_i) ? cdb_i.value : regs[rs1_tag_i];
    assign rs2_val_o = (wr_en && cdb_i.pd == rs2_tag_i) ? cdb_i.value : regs[rs2_tag_i];

endmodule

`default_nettype wire

// ==== hw/alu_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               issue_valid_i,
    input  ooo_pkg::uop_t      issue_uop_i,
    input  logic [31:0]        rs1_val_i,
    input  logic [31:0]        rs2_val_i,
    output ooo_pkg::phys_reg_t rs1_tag_o,
    output ooo_pkg::phys_reg_t rs2_tag_o,
    output ooo_pkg::cdb_t      cdb_o
);

    logic [31:0] opb;
    logic [31:0] result;
    logic [4:0]  shamt;

    assign rs1_tag_o = issue_uop_i.ps1;
    assign rs2_tag_o = issue_uop_i.ps2;
    assign opb       = issue_uop_i.use_imm ? issue_uop_i.imm : rs2_val_i;
    assign shamt     = opb[4:0];

    always_comb begin
        case (issue_uop_i.alu_op)
            ooo_pkg::ALU_ADD:  result = rs1_val_i + opb;
            ooo_pkg::ALU_SUB:  result = rs1_val_i - opb;
            ooo_pkg::ALU_SLL:  result = rs1_val_i << shamt;
            ooo_pkg::ALU_SLT:  result = {31'b0, $signed(rs1_val_i) < $signed(opb)};
            ooo_pkg::ALU_SLTU: result = {31'b0, rs1_val_i < opb};
            ooo_pkg::ALU_XOR:  result = rs1_val_i ^ opb;
            ooo_pkg::ALU_SRL:  result = rs1_val_i >> shamt;
            ooo_pkg::ALU_SRA:  result = $signed(rs1_val_i) >>> shamt;
            ooo_pkg::ALU_OR:   result = rs1_val_i | opb;
            ooo_pkg::ALU_AND:  result = rs1_val_i & opb;
            default:           result = rs1_val_i + opb;
        endcase
    end

    always_ff @(posedge clk) begin
        cdb_o.pd        <= issue_uop_i.pd;
        cdb_o.rob_idx   <= issue_uop_i.rob_idx;
        cdb_o.value     <= result;
        cdb_o.writes_rd <= issue_uop_i.writes_rd;
        if (rst) cdb_o.valid <= 1'b0;
        else     cdb_o.valid <= issue_valid_i;
    end

endmodule

`default_nettype wire

// ==== hw/ooo_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo_core #(
    parameter int IQ_DEPTH  = 8,
    parameter int ROB_DEPTH = 16,   // at most 16, the rob_idx_t range
    parameter int RS_DEPTH  = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             inst_valid_i,
    input  ooo_pkg::inst_u   inst_i,
    output logic             credit_o,
    output logic             commit_valid_o,
    output ooo_pkg::commit_t commit_o
);

    ooo_pkg::inst_u     iq_head;
    ooo_pkg::uop_t      uop;
    ooo_pkg::uop_t      issue_uop;
    ooo_pkg::cdb_t      cdb;
    ooo_pkg::rob_idx_t  rob_tail;
    ooo_pkg::phys_reg_t fl_tag;
    ooo_pkg::phys_reg_t free_tag;
    ooo_pkg::phys_reg_t old_pd;
    ooo_pkg::phys_reg_t rs1_tag;
    ooo_pkg::phys_reg_t rs2_tag;
    logic [31:0]        rs1_val;
    logic [31:0]        rs2_val;
    logic               iq_empty;
    logic               iq_pop;
    logic               fl_empty;
    logic               fl_alloc;
    logic               fl_free;
    logic               rob_full;
    logic               dispatch;   // rob and rs push together
    logic               rs_full;
    logic               issue_valid;

    inst_queue #(.IQ_DEPTH(IQ_DEPTH)) u_inst_queue (
        .clk(clk), .rst(rst),
        .push_i(inst_valid_i), .push_data_i(inst_i),
        .pop_i(iq_pop), .head_o(iq_head), .empty_o(iq_empty), .credit_o(credit_o)
    );

    rename_dispatch u_rename_dispatch (
        .clk(clk), .rst(rst),
        .inst_i(iq_head), .iq_empty_i(iq_empty), .pop_o(iq_pop),
        .fl_empty_i(fl_empty), .fl_tag_i(fl_tag), .fl_alloc_o(fl_alloc),
        .rob_full_i(rob_full), .rob_tail_i(rob_tail), .rob_push_o(dispatch),
        .old_pd_o(old_pd), .rs_full_i(rs_full), .uop_o(uop), .cdb_i(cdb)
    );

    free_list u_free_list (
        .clk(clk), .rst(rst),
        .alloc_i(fl_alloc), .tag_o(fl_tag), .empty_o(fl_empty),
        .free_i(fl_free), .free_tag_i(free_tag)
    );

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) u_reorder_buffer (
        .clk(clk), .rst(rst),
        .push_i(dispatch), .push_uop_i(uop), .old_pd_i(old_pd),
        .tail_o(rob_tail), .full_o(rob_full), .cdb_i(cdb),
        .commit_valid_o(commit_valid_o), .commit_o(commit_o),
        .free_o(fl_free), .free_tag_o(free_tag)
    );

    reservation_station #(.RS_DEPTH(RS_DEPTH)) u_reservation_station (
        .clk(clk), .rst(rst),
        .push_i(dispatch), .uop_i(uop), .full_o(rs_full), .cdb_i(cdb),
        .issue_valid_o(issue_valid), .issue_uop_o(issue_uop)
    );

    phys_regfile u_phys_regfile (
        .clk(clk), .rst(rst), .cdb_i(cdb),
        .rs1_tag_i(rs1_tag), .rs2_tag_i(rs2_tag),
        .rs1_val_o(rs1_val), .rs2_val_o(rs2_val)
    );

    alu_unit u_alu_unit (
        .clk(clk), .rst(rst),
        .issue_valid_i(issue_valid), .issue_uop_i(issue_uop),
        .rs1_val_i(rs1_val), .rs2_val_i(rs2_val),
        .rs1_tag_o(rs1_tag), .rs2_tag_o(rs2_tag), .cdb_o(cdb)
    );

endmodule

`default_nettype wire

// ==== tests/ooo_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo_core_tb;

    localparam int IQ_DEPTH   = 8;
    localparam int CLK_PERIOD = 10;

    logic             clk;
    logic             rst;
    logic             inst_valid_i;
    ooo_pkg::inst_u   inst_i;
    logic             credit_o;
    logic             commit_valid_o;
    ooo_pkg::commit_t commit_o;

    // stimulus table and the expected commits from the reference model
    string       row_name [$];
    logic [31:0] row_word [$];
    bit          row_stall [$];
    logic [4:0]  exp_rd [$];
    bit          exp_wr [$];
    logic [31:0] exp_val [$];

    int n_rows     = 0;
    int errors     = 0;
    int commit_cnt = 0;
    int credits    = IQ_DEPTH;   // held by the sender
    int seed       = 63;

    ooo_core #(.IQ_DEPTH(IQ_DEPTH)) u_ooo_core (
        .clk(clk), .rst(rst),
        .inst_valid_i(inst_valid_i), .inst_i(inst_i), .credit_o(credit_o),
        .commit_valid_o(commit_valid_o), .commit_o(commit_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    // rv32i integer result where alt picks sub or sra
    function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic alt,
                                               input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = {31'b0, $signed(a) < $signed(b)};
            3'd3: r = {31'b0, a < b};
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) r = $signed(a) >>> b[4:0];
                else     r = a >> b[4:0];
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    task automatic add_row(input string name, input logic [31:0] word, input bit stall);
        row_name.push_back(name);
        row_word.push_back(word);
        row_stall.push_back(stall);
    endtask

    task automatic build_table;
        add_row("addi_pos", i_type(12'd5, 5'd0, 3'd0, 5'd1), 1'b1);
        add_row("addi_neg", i_type(12'hffd, 5'd0, 3'd0, 5'd2), 1'b0);
        add_row("add", r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd3), 1'b1);
        add_row("sub", r_type(7'h20, 5'd2, 5'd1, 3'd0, 5'd4), 1'b0);
        add_row("sll", r_type(7'h00, 5'd1, 5'd1, 3'd1, 5'd5), 1'b1);
        add_row("slt", r_type(7'h00, 5'd1, 5'd2, 3'd2, 5'd6), 1'b0);
        add_row("sltu", r_type(7'h00, 5'd1, 5'd2, 3'd3, 5'd7), 1'b1);
        add_row("xor", r_type(7'h00, 5'd2, 5'd1, 3'd4, 5'd8), 1'b0);
        add_row("srl", r_type(7'h00, 5'd1, 5'd2, 3'd5, 5'd9), 1'b1);
        add_row("sra", r_type(7'h20, 5'd1, 5'd2, 3'd5, 5'd10), 1'b0);
        add_row("or", r_type(7'h00, 5'd2, 5'd1, 3'd6, 5'd11), 1'b1);
        add_row("and", r_type(7'h00, 5'd2, 5'd1, 3'd7, 5'd12), 1'b0);
        add_row("slti", i_type(12'hfff, 5'd2, 3'd2, 5'd13), 1'b1);
        add_row("sltiu", i_type(12'hfff, 5'd1, 3'd3, 5'd14), 1'b0);
        add_row("xori", i_type(12'h7ff, 5'd1, 3'd4, 5'd15), 1'b1);
        add_row("ori", i_type(12'h100, 5'd2, 3'd6, 5'd16), 1'b0);
        add_row("andi", i_type(12'h0f0, 5'd2, 3'd7, 5'd17), 1'b1);
        add_row("slli", i_type(12'h004, 5'd2, 3'd1, 5'd18), 1'b0);
        add_row("srli", i_type(12'h01c, 5'd2, 3'd5, 5'd19), 1'b1);
        add_row("srai", i_type(12'h401, 5'd2, 3'd5, 5'd20), 1'b0);
        // back to back dependences
        add_row("chain_add", r_type(7'h00, 5'd4, 5'd3, 3'd0, 5'd21), 1'b0);
        add_row("indep_addi", i_type(12'd9, 5'd1, 3'd0, 5'd25), 1'b0);   // next one meets the cdb
        add_row("chain_dbl", r_type(7'h00, 5'd21, 5'd21, 3'd0, 5'd21), 1'b0);
        add_row("chain_addi", i_type(12'hff9, 5'd21, 3'd0, 5'd21), 1'b0);
        add_row("chain_sub", r_type(7'h20, 5'd2, 5'd21, 3'd0, 5'd22), 1'b0);
        add_row("chain_sll", r_type(7'h00, 5'd1, 5'd22, 3'd1, 5'd23), 1'b0);
        add_row("chain_srai", i_type(12'h403, 5'd23, 3'd5, 5'd23), 1'b0);
        add_row("chain_sltu", r_type(7'h00, 5'd23, 5'd0, 3'd3, 5'd24), 1'b0);
        add_row("write_x0", i_type(12'd7, 5'd1, 3'd0, 5'd0), 1'b1);
        add_row("write_x0_reg", r_type(7'h20, 5'd2, 5'd1, 3'd0, 5'd0), 1'b0);
        add_row("read_x0", r_type(7'h00, 5'd1, 5'd0, 3'd0, 5'd25), 1'b1);
        add_row("nop_ecall", 32'h0000_0073, 1'b1);
        add_row("nop_load", {12'd0, 5'd1, 3'b010, 5'd3, 7'b0000011}, 1'b0);
        add_row("x3_kept", i_type(12'd0, 5'd3, 3'd0, 5'd25), 1'b1);
        // more writes than free tags
        for (int k = 0; k < 40; k++) begin
            if (k % 4 == 3) begin
                add_row($sformatf("burst_%0d", k),
                        r_type(7'h00, 5'd1, 5'(26 + (k + 5) % 6), 3'd0, 5'(26 + k % 6)), 1'b0);
            end else begin
                add_row($sformatf("burst_%0d", k),
                        i_type(12'(k + 1), 5'(26 + (k + 5) % 6), 3'd0, 5'(26 + k % 6)), 1'b0);
            end
        end
    endtask

    task automatic run_reference;
        logic [31:0] x [32];
        logic [31:0] w;
        logic [31:0] val;
        bit          wr;
        for (int r = 0; r < 32; r++) x[r] = '0;
        foreach (row_word[n]) begin
            w   = row_word[n];
            val = '0;
            wr  = 1'b0;
            if (w[6:0] == 7'b0110011) begin
                val = alu_result(w[14:12], w[30], x[w[19:15]], x[w[24:20]]);
                wr  = 1'b1;
            end else if (w[6:0] == 7'b0010011) begin
                val = alu_result(w[14:12], w[14:12] == 3'd5 && w[30], x[w[19:15]],
                                 {{20{w[31]}}, w[31:20]});
                wr  = 1'b1;
            end
            wr = wr && w[11:7] != 5'd0;
            if (wr) x[w[11:7]] = val;
            exp_rd.push_back(w[11:7]);
            exp_wr.push_back(wr);
            exp_val.push_back(val);
        end
    endtask

    task automatic report_mismatch(input string name, input string field,
                                   input logic [31:0] expected, input logic [31:0] actual);
        errors++;
        $display("CHECK FAILED %s %s: expected %h, actual %h", name, field, expected, actual);
    endtask

    // step to the falling edge and count a returned credit
    task automatic next_cycle;
        @(negedge clk);
        if (credit_o) credits++;
        if (credits < 0 || credits > IQ_DEPTH) begin
            errors++;
            $display("sender credit count out of range: %0d", credits);
        end
    endtask

    always @(negedge clk) begin
        if (!rst && commit_valid_o) begin
            if (commit_cnt >= exp_rd.size()) begin
                errors++;
                $display("commit seen after the last table row");
            end else begin
                if (commit_o.order != 32'(commit_cnt))
                    report_mismatch(row_name[commit_cnt], "order", 32'(commit_cnt), commit_o.order);
                if (commit_o.rd != exp_rd[commit_cnt])
                    report_mismatch(row_name[commit_cnt], "rd", 32'(exp_rd[commit_cnt]),
                                    32'(commit_o.rd));
                if (commit_o.writes_rd != exp_wr[commit_cnt])
                    report_mismatch(row_name[commit_cnt], "writes_rd", 32'(exp_wr[commit_cnt]),
                                    32'(commit_o.writes_rd));
                if (exp_wr[commit_cnt] && commit_o.value != exp_val[commit_cnt])
                    report_mismatch(row_name[commit_cnt], "value", exp_val[commit_cnt],
                                    commit_o.value);
            end
            commit_cnt++;
        end
    end

    initial begin
        wait (n_rows > 0);
        repeat (10 + 200 * n_rows) @(posedge clk);
        $display("timeout: only %0d of %0d instructions committed", commit_cnt, n_rows);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        int gap;
        clk          = 1'b0;
        rst          = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        build_table();
        run_reference();
        n_rows = row_word.size();
        repeat (10) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < n_rows; i++) begin
            inst_valid_i = 1'b0;
            if (row_stall[i]) begin
                gap = $unsigned($random(seed)) % 4;
                repeat (gap) next_cycle();
            end
            while (credits == 0) next_cycle();
            inst_valid_i = 1'b1;
            inst_i       = ooo_pkg::inst_u'(row_word[i]);
            credits--;
            next_cycle();
        end
        inst_valid_i = 1'b0;
        while (commit_cnt < n_rows) next_cycle();
        repeat (5) next_cycle();
        if (credits != IQ_DEPTH) begin
            errors++;
            $display("sender ended with %0d credits instead of %0d", credits, IQ_DEPTH);
        end
        $display("errors: %0d, commits: %0d of %0d", errors, commit_cnt, n_rows);
        if (errors == 0 && commit_cnt == n_rows) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
hw/ooo_pkg.sv
hw/inst_queue.sv
hw/free_list.sv
hw/rename_dispatch.sv
hw/reorder_buffer.sv
hw/reservation_station.sv
hw/phys_regfile.sv
hw/alu_unit.sv
hw/ooo_core.sv
tests/ooo_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= ooo_core_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -sv

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
